/* design/rowsum_pkg.sv */
package rowsum_pkg;

  // sample and sum formats
  localparam int DATA_W = 8;
  // 12 x 255 = 3060 fits in 12 bits
  localparam int SUM_W = 12;

  // block geometry
  localparam int COLS = 15;
  localparam int WIN = 12;
  localparam int OUTS = COLS - WIN + 1;
  localparam int ROWS = 8;
  localparam int LANES = 4;
  localparam int GROUPS = ROWS / LANES;

  // counter widths
  localparam int COL_W = 4;
  localparam int GRP_W = 1;

  // store sizes and index widths
  localparam int SAMPLES = ROWS * COLS;
  localparam int RESULTS = ROWS * OUTS;
  localparam int SMP_IDX_W = $clog2(SAMPLES);
  localparam int RES_IDX_W = $clog2(RESULTS);

  // wishbone bus
  localparam int ADR_W = 8;
  localparam int DAT_W = 32;

  // address map, in words
  localparam int SAMPLE_BASE = 0;
  localparam int RESULT_BASE = 128;
  // write bit 0 = start, read bit 0 = busy, bit 1 = done
  localparam int CTRL_ADDR = 255;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    START    = 3'd1,
    LOAD_ROW = 3'd2,
    SUM      = 3'd3,
    CUM      = 3'd4,
    FINISH   = 3'd5
  } seq_state_e;

endpackage

/* design/rowsum_wb_port.sv */
`timescale 1ns/10ps

module rowsum_wb_port (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             i_wb_cyc,
  input  logic                                             i_wb_stb,
  input  logic                                             i_wb_we,
  input  logic [rowsum_pkg::ADR_W-1:0]                     i_wb_adr,
  input  logic [rowsum_pkg::DAT_W-1:0]                     i_wb_dat,
  input  logic                                             i_busy,
  input  logic                                             i_finish,
  input  logic [rowsum_pkg::COL_W-1:0]                     i_col,
  input  logic [rowsum_pkg::GRP_W-1:0]                     i_group,
  input  logic [rowsum_pkg::SUM_W-1:0]                     i_res_data,
  output logic [rowsum_pkg::DAT_W-1:0]                     o_wb_dat,
  output logic                                             o_wb_ack,
  output logic                                             o_start,
  output logic [rowsum_pkg::LANES*rowsum_pkg::DATA_W-1:0]  o_lane_samples,
  output logic [rowsum_pkg::RES_IDX_W-1:0]                 o_res_addr
);
  import rowsum_pkg::*;

  // sample store, row-major
  logic [DATA_W-1:0] smp_mem [SAMPLES];

  logic             req;
  logic             is_smp;
  logic             is_res;
  logic             is_ctrl;
  logic [ADR_W-1:0] adr_off_smp;
  logic [ADR_W-1:0] adr_off_res;
  logic             start_wr;
  logic             eng_busy;
  logic             done;
  logic [DAT_W-1:0] rd_data;

  // new access only while ack is low
  assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

  // region decode by offset from each base
  assign adr_off_smp = i_wb_adr - ADR_W'(SAMPLE_BASE);
  assign adr_off_res = i_wb_adr - ADR_W'(RESULT_BASE);
  assign is_smp      = (adr_off_smp < ADR_W'(SAMPLES));
  assign is_res      = (adr_off_res < ADR_W'(RESULTS));
  assign is_ctrl     = (i_wb_adr == ADR_W'(CTRL_ADDR));

  // result index goes straight to the collector
  assign o_res_addr = adr_off_res[RES_IDX_W-1:0];

  // o_start covers the cycle before busy rises
  assign eng_busy = i_busy | o_start;
  assign start_wr = req & i_wb_we & is_ctrl & i_wb_dat[0] & ~eng_busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      done     <= 1'b0;
    end else begin
      o_wb_ack <= req;
      o_start  <= start_wr;
      // sticky done, cleared by a new run
      if (start_wr) begin
        done <= 1'b0;
      end else if (i_finish) begin
        done <= 1'b1;
      end
    end
  end

  // sample writes, locked out while the engine runs
  always_ff @(posedge clk) begin
    if (req && i_wb_we && is_smp && !eng_busy) begin
      smp_mem[adr_off_smp[SMP_IDX_W-1:0]] <= i_wb_dat[DATA_W-1:0];
    end
  end

  // read mux, unmapped reads give zero
  always_comb begin
    rd_data = '0;
    if (is_smp) begin
      rd_data = DAT_W'(smp_mem[adr_off_smp[SMP_IDX_W-1:0]]);
    end else if (is_res) begin
      rd_data = DAT_W'(i_res_data);
    end else if (is_ctrl) begin
      rd_data = DAT_W'({done, i_busy});
    end
  end

  // captured with the request, held while ack is high
  always_ff @(posedge clk) begin
    if (req && !i_wb_we) begin
      o_wb_dat <= rd_data;
    end
  end

  // one sample per lane for the current column
  for (genvar l = 0; l < LANES; l++) begin : g_lane_sel
    logic [SMP_IDX_W-1:0] idx;

    // row = group * LANES + lane
    assign idx = SMP_IDX_W'((int'(i_group) * LANES + l) * COLS) + SMP_IDX_W'(i_col);
    assign o_lane_samples[l*DATA_W +: DATA_W] = smp_mem[idx];
  end

endmodule

/* design/rowsum_sequencer.sv */
`timescale 1ns/10ps

module rowsum_sequencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_start,
  output logic                          o_busy,
  output logic                          o_finish,
  output logic [rowsum_pkg::COL_W-1:0]  o_col,
  output logic [rowsum_pkg::GRP_W-1:0]  o_group,
  output logic                          o_clear,
  output logic                          o_acc_en,
  output logic                          o_win_full,
  output logic                          o_emit
);
  import rowsum_pkg::*;

  seq_state_e       state;
  seq_state_e       state_nxt;
  logic [COL_W-1:0] col;
  logic [COL_W-1:0] col_nxt;
  logic [GRP_W-1:0] grp;
  logic             last_col;
  logic             last_grp;

  assign last_col = (col == COL_W'(COLS - 1));
  assign last_grp = (grp == GRP_W'(GROUPS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      col   <= '0;
      grp   <= '0;
    end else begin
      state <= state_nxt;
      col   <= col_nxt;
      // group restarts with each run, steps after a row's last column
      if (state == START) begin
        grp <= '0;
      end else if (state == CUM && last_col) begin
        grp <= grp + GRP_W'(1);
      end
    end
  end

  // column counts only in SUM and CUM, otherwise parked at 0
  always_comb begin
    col_nxt = '0;
    if ((state == SUM || state == CUM) && !last_col) begin
      col_nxt = col + COL_W'(1);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (i_start) begin
          state_nxt = START;
        end
      end
      START: state_nxt = LOAD_ROW;
      LOAD_ROW: state_nxt = SUM;
      SUM: begin
        // column WIN-1 completes the first full window
        if (col == COL_W'(WIN - 2)) begin
          state_nxt = CUM;
        end
      end
      CUM: begin
        if (last_col) begin
          state_nxt = last_grp ? FINISH : LOAD_ROW;
        end
      end
      FINISH: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // controls decoded from the state register
  always_comb begin
    o_clear    = 1'b0;
    o_acc_en   = 1'b0;
    o_win_full = 1'b0;
    o_emit     = 1'b0;
    case (state)
      LOAD_ROW: o_clear = 1'b1;
      SUM: o_acc_en = 1'b1;
      CUM: begin
        o_acc_en   = 1'b1;
        o_win_full = 1'b1;
        o_emit     = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign o_busy   = (state != IDLE);
  assign o_finish = (state == FINISH);
  assign o_col    = col;
  assign o_group  = grp;

endmodule

/* design/window_sum_lane.sv */
`timescale 1ns/10ps

module window_sum_lane (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [rowsum_pkg::DATA_W-1:0]  i_sample,
  input  logic                           i_clear,
  input  logic                           i_acc_en,
  input  logic                           i_win_full,
  output logic [rowsum_pkg::SUM_W-1:0]   o_sum
);
  import rowsum_pkg::*;

  // hist[0] newest, hist[WIN-1] leaves the window next
  logic [DATA_W-1:0] hist [WIN];
  logic [SUM_W-1:0]  leaving;

  // at the first full column the oldest slot still holds the cleared zero
  assign leaving = i_win_full ? SUM_W'(hist[WIN-1]) : '0;

  // running sum
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_sum <= '0;
    end else if (i_clear) begin
      o_sum <= '0;
    end else if (i_acc_en) begin
      o_sum <= o_sum + SUM_W'(i_sample) - leaving;
    end
  end

  // sample history
  always_ff @(posedge clk) begin
    if (i_clear) begin
      for (int i = 0; i < WIN; i++) begin
        hist[i] <= '0;
      end
    end else if (i_acc_en) begin
      hist[0] <= i_sample;
      for (int i = 1; i < WIN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

endmodule

/* design/result_collector.sv */
`timescale 1ns/10ps

module result_collector (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            i_emit,
  input  logic [rowsum_pkg::COL_W-1:0]                    i_col,
  input  logic [rowsum_pkg::GRP_W-1:0]                    i_group,
  input  logic [rowsum_pkg::LANES*rowsum_pkg::SUM_W-1:0]  i_lane_sums,
  input  logic [rowsum_pkg::RES_IDX_W-1:0]                i_res_addr,
  output logic [rowsum_pkg::SUM_W-1:0]                    o_res_data
);
  import rowsum_pkg::*;

  // result store, row-major by output slot
  logic [SUM_W-1:0] res_mem [RESULTS];

  logic             emit_q;
  logic [COL_W-1:0] col_q;
  logic [GRP_W-1:0] grp_q;

  // store slot for one lane of the delayed column
  function automatic logic [RES_IDX_W-1:0] wr_idx(input int lane);
    int row;
    int slot;
    row  = int'(grp_q) * LANES + lane;
    slot = int'(col_q) - (WIN - 1);
    return RES_IDX_W'(row * OUTS + slot);
  endfunction

  // lane sums lag the emitting column by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      emit_q <= 1'b0;
    end else begin
      emit_q <= i_emit;
    end
  end

  always_ff @(posedge clk) begin
    col_q <= i_col;
    grp_q <= i_group;
  end

  // all lanes land in the same cycle
  always_ff @(posedge clk) begin
    if (emit_q) begin
      for (int l = 0; l < LANES; l++) begin
        res_mem[wr_idx(l)] <= i_lane_sums[l*SUM_W +: SUM_W];
      end
    end
  end

  assign o_res_data = res_mem[i_res_addr];

endmodule

/* design/rowsum_top.sv */
`timescale 1ns/10ps

module rowsum_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_wb_cyc,
  input  logic                          i_wb_stb,
  input  logic                          i_wb_we,
  input  logic [rowsum_pkg::ADR_W-1:0]  i_wb_adr,
  input  logic [rowsum_pkg::DAT_W-1:0]  i_wb_dat,
  output logic [rowsum_pkg::DAT_W-1:0]  o_wb_dat,
  output logic                          o_wb_ack
);
  import rowsum_pkg::*;

  logic                      start;
  logic                      busy;
  logic                      finish;
  logic [COL_W-1:0]          col;
  logic [GRP_W-1:0]          group;
  logic                      clear;
  logic                      acc_en;
  logic                      win_full;
  logic                      emit;
  logic [LANES*DATA_W-1:0]   lane_samples;
  logic [LANES*SUM_W-1:0]    lane_sums;
  logic [RES_IDX_W-1:0]      res_addr;
  logic [SUM_W-1:0]          res_data;

  // host side, sample store and control
  rowsum_wb_port u_wb_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .i_busy         (busy),
    .i_finish       (finish),
    .i_col          (col),
    .i_group        (group),
    .i_res_data     (res_data),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .o_start        (start),
    .o_lane_samples (lane_samples),
    .o_res_addr     (res_addr)
  );

  rowsum_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (start),
    .o_busy     (busy),
    .o_finish   (finish),
    .o_col      (col),
    .o_group    (group),
    .o_clear    (clear),
    .o_acc_en   (acc_en),
    .o_win_full (win_full),
    .o_emit     (emit)
  );

  // one lane per row of the current group
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    window_sum_lane u_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_sample   (lane_samples[l*DATA_W +: DATA_W]),
      .i_clear    (clear),
      .i_acc_en   (acc_en),
      .i_win_full (win_full),
      .o_sum      (lane_sums[l*SUM_W +: SUM_W])
    );
  end

  result_collector u_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_emit      (emit),
    .i_col       (col),
    .i_group     (group),
    .i_lane_sums (lane_sums),
    .i_res_addr  (res_addr),
    .o_res_data  (res_data)
  );

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int RESET_CYCLES = 16;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // released on a falling edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tb/tb_rowsum.sv */
`timescale 1ns/10ps

module tb_rowsum;
  import rowsum_pkg::*;

  // some 620 bus accesses of three cycles each, plus reset and polling
  localparam int TIMEOUT_CYCLES = 3000;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [DAT_W-1:0] wb_dat_w;
  logic [DAT_W-1:0] wb_dat_r;
  logic             wb_ack;
  logic             req_seen;
  int               cycles = 0;
  integer           seed;
  logic [DATA_W-1:0] model_smp [ROWS][COLS];

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rowsum_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack)
  );

  // request as the slave saw it on the last rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      req_seen <= 1'b0;
    end else begin
      req_seen <= wb_cyc & wb_stb;
    end
  end

  // ack and req_seen only move on rising edges, so check them on falling ones
  ack_one_cycle: assert property (@(negedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
      $display("ack was high for two cycles in a row");
      $display("TEST FAIL");
      $fatal(1, "wishbone protocol error");
    end

  ack_after_req: assert property (@(negedge clk) disable iff (!rst_n) wb_ack |-> req_seen)
    else begin
      $display("ack came without a request on the cycle before");
      $display("TEST FAIL");
      $fatal(1, "wishbone protocol error");
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input int exp_val, input int act_val);
    assert (act_val == exp_val) else begin
      $display("Fail %s: expected %0d, actual %0d", name, exp_val, act_val);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // stb stays up through the edge that carries ack
  task automatic wb_write(input int adr, input logic [DAT_W-1:0] dat);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = ADR_W'(adr);
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input int adr, output logic [DAT_W-1:0] dat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = ADR_W'(adr);
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    dat    = wb_dat_r;
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // plain sum of samples r,k .. r,k+WIN-1
  function automatic int window_sum(input int r, input int k);
    int acc;
    acc = 0;
    for (int c = k; c < k + WIN; c++) begin
      acc += int'(model_smp[r][c]);
    end
    return acc;
  endfunction

  task automatic load_random();
    logic [31:0] rnd;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        rnd = $random(seed);
        model_smp[r][c] = rnd[DATA_W-1:0];
        wb_write(SAMPLE_BASE + r * COLS + c, DAT_W'(model_smp[r][c]));
      end
    end
  endtask

  // full scale everywhere, rows 1 and 6 zero
  task automatic load_extremes();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        model_smp[r][c] = (r == 1 || r == 6) ? 8'd0 : 8'd255;
        wb_write(SAMPLE_BASE + r * COLS + c, DAT_W'(model_smp[r][c]));
      end
    end
  endtask

  task automatic check_samples();
    logic [DAT_W-1:0] val;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        wb_read(SAMPLE_BASE + r * COLS + c, val);
        check_value($sformatf("sample r%0d c%0d", r, c), int'(model_smp[r][c]), int'(val));
      end
    end
  endtask

  // start, then busy must show with done cleared
  task automatic start_run(input string name);
    logic [DAT_W-1:0] st;
    wb_write(CTRL_ADDR, 32'h1);
    wb_read(CTRL_ADDR, st);
    check_value({name, " status after start"}, 1, int'(st));
  endtask

  task automatic wait_done(input string name);
    logic [DAT_W-1:0] st;
    wb_read(CTRL_ADDR, st);
    while (st[1] == 1'b0) wb_read(CTRL_ADDR, st);
    check_value({name, " status at done"}, 2, int'(st));
  endtask

  task automatic check_results(input string name);
    logic [DAT_W-1:0] val;
    for (int r = 0; r < ROWS; r++) begin
      for (int k = 0; k < OUTS; k++) begin
        wb_read(RESULT_BASE + r * OUTS + k, val);
        check_value($sformatf("%s result r%0d k%0d", name, r, k), window_sum(r, k), int'(val));
      end
    end
  endtask

  initial begin
    logic [DAT_W-1:0] val;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 32'h5a5cfcfe;
    wait (rst_n == 1'b1);

    // idle status
    wb_read(CTRL_ADDR, val);
    check_value("status after reset", 0, int'(val));

    // sample store readback and unmapped holes
    load_random();
    check_samples();
    wb_read(120, val);
    check_value("unmapped read 120", 0, int'(val));
    wb_read(200, val);
    check_value("unmapped read 200", 0, int'(val));

    // random run
    start_run("random");
    wait_done("random");
    check_results("random");

    // result region is read only
    wb_write(RESULT_BASE + 5, 32'habc);
    wb_read(RESULT_BASE + 5, val);
    check_value("result write ignored", window_sum(1, 1), int'(val));

    // full scale and zero rows
    load_extremes();
    start_run("extremes");
    wait_done("extremes");
    check_results("extremes");

    // start and sample write during a run are dropped
    load_random();
    start_run("busy");
    wb_write(CTRL_ADDR, 32'h1);
    wb_write(SAMPLE_BASE, DAT_W'(~model_smp[0][0]));
    wait_done("busy");
    check_results("busy");
    wb_read(SAMPLE_BASE, val);
    check_value("sample write while busy", int'(model_smp[0][0]), int'(val));

    $display("TEST PASS");
    $finish;
  end

endmodule

/* rowsum.f */
design/rowsum_pkg.sv
design/rowsum_wb_port.sv
design/rowsum_sequencer.sv
design/window_sum_lane.sv
design/result_collector.sv
design/rowsum_top.sv
tb/tb_clkgen.sv
tb/tb_rowsum.sv

/* Makefile */
TOP := tb_rowsum

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP) -f rowsum.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
